// ==== mips_pkg.sv ====
`default_nettype none

package mips_pkg;

  typedef logic [31:0] word_t;     // data word or byte address.
  typedef logic [4:0]  reg_idx_t;  // architectural register index.
  typedef logic [31:0] instr_t;    // raw instruction word.

  localparam word_t reset_vector = 32'hbfc0_0000;  // first fetch after reset.

  // primary opcodes, bits 31:26.
  localparam logic [5:0] op_special = 6'h00;  // r-type, decoded by funct.
  localparam logic [5:0] op_j       = 6'h02;
  localparam logic [5:0] op_beq     = 6'h04;
  localparam logic [5:0] op_bne     = 6'h05;
  localparam logic [5:0] op_addiu   = 6'h09;
  localparam logic [5:0] op_ori     = 6'h0d;
  localparam logic [5:0] op_lui     = 6'h0f;

  // function codes of op_special, bits 5:0.
  localparam logic [5:0] fn_addu = 6'h21;
  localparam logic [5:0] fn_subu = 6'h23;
  localparam logic [5:0] fn_and  = 6'h24;
  localparam logic [5:0] fn_or   = 6'h25;
  localparam logic [5:0] fn_slt  = 6'h2a;

  typedef enum logic [2:0] {
    alu_add,  // addu, addiu.
    alu_sub,  // subu.
    alu_and,
    alu_or,   // or, ori.
    alu_slt,  // signed compare.
    alu_lui,  // immediate into the upper half.
    alu_nop   // branches, jumps and unknown opcodes.
  } alu_op_t;

  typedef enum logic [1:0] {
    br_none,
    br_eq,
    br_ne,
    br_jump
  } branch_kind_t;

  typedef enum logic [1:0] {
    st_fetch,  // waiting for the instruction transfer.
    st_e1,     // decode and register read.
    st_e2      // execute, write back, pc iteration.
  } seq_state_t;

endpackage

`default_nettype wire

// ==== mips_pc.sv ====
`default_nettype none

module mips_pc (
  input  logic            clk,
  input  logic            reset,
  input  logic            wen,            // one iteration per instruction, in e2.
  input  logic            branch_taken,   // resolved by the instruction in e2.
  input  mips_pkg::word_t branch_target,
  output mips_pkg::word_t pc
);
  import mips_pkg::*;

  word_t pc_q;
  word_t pc_next;
  word_t target_q;   // target of the last taken branch.
  logic  pending_q;  // previous iteration resolved a taken branch.

  assign pc = pc_q;  // also the fetch address.

  // a pending branch redirects this iteration, so the slot after
  // the branch has already been fetched from pc+4.
  always_comb begin
    if (pending_q) begin
      pc_next = target_q;  // delay slot done, go to the target.
    end else begin
      pc_next = pc_q + 32'd4;  // sequential.
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q      <= reset_vector;  // held while reset is high.
      pending_q <= 1'b0;
    end else if (wen) begin
      pc_q      <= pc_next;
      pending_q <= branch_taken;  // takes effect next iteration.
    end
  end

  // target is taken only at the iteration edge; outside e2 the
  // execute stage sees a pc that no longer matches the branch.
  always_ff @(posedge clk) begin
    if (wen && branch_taken) begin
      target_q <= branch_target;
    end
  end

endmodule

`default_nettype wire

// ==== mips_sequencer.sv ====
`default_nettype none

module mips_sequencer (
  input  logic clk,
  input  logic reset,
  input  logic imem_ready,
  output logic imem_valid,  // registered request.
  output logic fetch_done,  // high in the cycle that ends in the transfer.
  output logic e2_en        // high for the whole of st_e2.
);
  import mips_pkg::*;

  seq_state_t state_q;
  seq_state_t state_next;
  logic       valid_q;

  assign imem_valid = valid_q;
  assign fetch_done = valid_q && imem_ready;  // handshake completes.
  assign e2_en      = (state_q == st_e2);

  always_comb begin
    state_next = state_q;
    case (state_q)
      st_fetch: begin
        if (fetch_done) begin
          state_next = st_e1;  // instruction captured by decode.
        end
      end
      st_e1: state_next = st_e2;     // operands settle.
      st_e2: state_next = st_fetch;  // pc steps at this edge.
      default: state_next = st_fetch;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= st_fetch;
      valid_q <= 1'b0;  // no request during reset.
    end else begin
      state_q <= state_next;
      // request stays up through stalls and drops at the transfer.
      valid_q <= (state_next == st_fetch);
    end
  end

endmodule

`default_nettype wire

// ==== mips_decode.sv ====
`default_nettype none

module mips_decode (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    fetch_done,
  input  mips_pkg::instr_t        imem_data,
  output mips_pkg::reg_idx_t      rs,
  output mips_pkg::reg_idx_t      rt,
  output mips_pkg::reg_idx_t      dest,
  output mips_pkg::word_t         imm,
  output mips_pkg::alu_op_t       alu_op,
  output logic                    use_imm,
  output logic                    writes_reg,
  output mips_pkg::branch_kind_t  branch_kind,
  output logic [25:0]             jump_index
);
  import mips_pkg::*;

  instr_t     ir_q;    // instruction being executed.
  logic [5:0] opcode;
  logic [5:0] funct;
  reg_idx_t   rd;

  always_ff @(posedge clk) begin
    if (reset) begin
      ir_q <= '0;  // decodes as a no-op.
    end else if (fetch_done) begin
      ir_q <= imem_data;
    end
  end

  assign opcode     = ir_q[31:26];
  assign funct      = ir_q[5:0];
  assign rs         = ir_q[25:21];
  assign rt         = ir_q[20:16];
  assign rd         = ir_q[15:11];
  assign jump_index = ir_q[25:0];
  assign dest       = (opcode == op_special) ? rd : rt;  // r-type writes rd.

  // ori takes the immediate zero extended, everything else signed.
  assign imm = (opcode == op_ori) ? {16'h0000, ir_q[15:0]}
                                  : {{16{ir_q[15]}}, ir_q[15:0]};

  always_comb begin
    alu_op      = alu_nop;  // unknown opcodes fall through as no-ops.
    use_imm     = 1'b0;
    writes_reg  = 1'b0;
    branch_kind = br_none;
    case (opcode)
      op_special: begin
        writes_reg = 1'b1;
        case (funct)
          fn_addu: alu_op = alu_add;
          fn_subu: alu_op = alu_sub;
          fn_and:  alu_op = alu_and;
          fn_or:   alu_op = alu_or;
          fn_slt:  alu_op = alu_slt;
          default: writes_reg = 1'b0;  // unsupported funct.
        endcase
      end
      op_addiu: begin
        alu_op     = alu_add;
        use_imm    = 1'b1;
        writes_reg = 1'b1;
      end
      op_ori: begin
        alu_op     = alu_or;
        use_imm    = 1'b1;
        writes_reg = 1'b1;
      end
      op_lui: begin
        alu_op     = alu_lui;
        use_imm    = 1'b1;
        writes_reg = 1'b1;
      end
      op_beq:  branch_kind = br_eq;
      op_bne:  branch_kind = br_ne;
      op_j:    branch_kind = br_jump;
      default: alu_op = alu_nop;
    endcase
  end

endmodule

`default_nettype wire

// ==== mips_regfile.sv ====
`default_nettype none

module mips_regfile (
  input  logic               clk,
  input  logic               we,
  input  mips_pkg::reg_idx_t waddr,
  input  mips_pkg::reg_idx_t raddr_a,
  input  mips_pkg::reg_idx_t raddr_b,
  input  mips_pkg::word_t    wdata,
  output mips_pkg::word_t    rdata_a,
  output mips_pkg::word_t    rdata_b
);
  import mips_pkg::*;

  word_t regs [32];  // entry 0 is never read.

  // write lands at the e2 edge, visible from the next cycle.
  always_ff @(posedge clk) begin
    if (we && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  // r0 is hardwired to zero.
  assign rdata_a = (raddr_a == 5'd0) ? '0 : regs[raddr_a];
  assign rdata_b = (raddr_b == 5'd0) ? '0 : regs[raddr_b];

endmodule

`default_nettype wire

// ==== mips_execute.sv ====
`default_nettype none

module mips_execute (
  input  mips_pkg::word_t        pc,           // address of this instruction.
  input  mips_pkg::word_t        op_a,         // rs value.
  input  mips_pkg::word_t        op_b,         // rt value.
  input  mips_pkg::word_t        imm,          // already extended.
  input  mips_pkg::alu_op_t      alu_op,
  input  logic                   use_imm,
  input  mips_pkg::branch_kind_t branch_kind,
  input  logic [25:0]            jump_index,
  output mips_pkg::word_t        alu_result,
  output mips_pkg::word_t        branch_target,
  output logic                   branch_taken
);
  import mips_pkg::*;

  word_t pc_plus4;
  word_t src_b;
  word_t sum;
  word_t diff;

  assign pc_plus4 = pc + 32'd4;
  assign src_b    = use_imm ? imm : op_b;
  assign sum      = op_a + src_b;
  assign diff     = op_a - src_b;

  always_comb begin
    case (alu_op)
      alu_add: alu_result = sum;
      alu_sub: alu_result = diff;
      alu_and: alu_result = op_a & src_b;
      alu_or:  alu_result = op_a | src_b;
      alu_slt: alu_result = {31'd0, $signed(op_a) < $signed(src_b)};  // signed.
      alu_lui: alu_result = {src_b[15:0], 16'h0000};
      default: alu_result = '0;  // no-op result.
    endcase
  end

  // beq and bne compare the two registers, never the immediate.
  always_comb begin
    case (branch_kind)
      br_eq:   branch_taken = (op_a == op_b);
      br_ne:   branch_taken = (op_a != op_b);
      br_jump: branch_taken = 1'b1;
      default: branch_taken = 1'b0;
    endcase
  end

  // j stays inside the 256 MB region of the delay slot.
  always_comb begin
    if (branch_kind == br_jump) begin
      branch_target = {pc_plus4[31:28], jump_index, 2'b00};
    end else begin
      branch_target = pc_plus4 + {imm[29:0], 2'b00};  // word offset.
    end
  end

endmodule

`default_nettype wire

// ==== mips_result.sv ====
`default_nettype none

module mips_result (
  input  logic               clk,
  input  logic               reset,
  input  logic               e2_en,
  input  logic               writes_reg,
  input  mips_pkg::reg_idx_t dest,
  input  mips_pkg::word_t    alu_result,
  input  mips_pkg::word_t    pc,
  output logic               rf_we,
  output logic               retire_valid,
  output logic               retire_we,
  output mips_pkg::reg_idx_t retire_rd,
  output mips_pkg::word_t    retire_data,
  output mips_pkg::word_t    retire_pc
);

  // writes to r0 are dropped here so retire_we reports them low.
  assign rf_we = e2_en && writes_reg && (dest != 5'd0);

  always_ff @(posedge clk) begin
    if (reset) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= e2_en;  // one pulse per instruction.
    end
  end

  // record is captured at the same edge as the register write.
  always_ff @(posedge clk) begin
    if (e2_en) begin
      retire_we   <= rf_we;
      retire_rd   <= dest;
      retire_data <= alu_result;
      retire_pc   <= pc;
    end
  end

endmodule

`default_nettype wire

// ==== mips_core.sv ====
`default_nettype none

module mips_core (
  input  logic               clk,
  input  logic               reset,
  input  logic               imem_ready,
  input  mips_pkg::instr_t   imem_data,
  output logic               imem_valid,
  output mips_pkg::word_t    imem_addr,
  output logic               retire_valid,
  output mips_pkg::word_t    retire_pc,
  output logic               retire_we,
  output mips_pkg::reg_idx_t retire_rd,
  output mips_pkg::word_t    retire_data
);
  import mips_pkg::*;

  logic         fetch_done;
  logic         e2_en;
  word_t        pc;
  reg_idx_t     rs;
  reg_idx_t     rt;
  reg_idx_t     dest;
  word_t        imm;
  alu_op_t      alu_op;
  logic         use_imm;
  logic         writes_reg;
  branch_kind_t branch_kind;
  logic [25:0]  jump_index;
  word_t        op_a;
  word_t        op_b;
  word_t        alu_result;
  word_t        branch_target;
  logic         branch_taken;
  logic         rf_we;

  assign imem_addr = pc;  // fetch straight from the pc.

  mips_sequencer u_seq (.clk, .reset, .imem_ready, .imem_valid, .fetch_done, .e2_en);

  mips_pc u_pc (.clk, .reset, .wen(e2_en), .branch_taken, .branch_target, .pc);

  mips_decode u_dec (.clk, .reset, .fetch_done, .imem_data, .rs, .rt, .dest, .imm,
                     .alu_op, .use_imm, .writes_reg, .branch_kind, .jump_index);

  mips_regfile u_rf (.clk, .we(rf_we), .waddr(dest), .raddr_a(rs), .raddr_b(rt),
                     .wdata(alu_result), .rdata_a(op_a), .rdata_b(op_b));

  mips_execute u_ex (.pc, .op_a, .op_b, .imm, .alu_op, .use_imm, .branch_kind,
                     .jump_index, .alu_result, .branch_target, .branch_taken);

  mips_result u_res (.clk, .reset, .e2_en, .writes_reg, .dest, .alu_result, .pc,
                     .rf_we, .retire_valid, .retire_we, .retire_rd, .retire_data,
                     .retire_pc);

endmodule

`default_nettype wire

// ==== mips_core_chk.sv ====
`default_nettype none

module mips_core_chk (
  input logic            clk,
  input logic            reset,
  input logic            imem_valid,
  input logic            imem_ready,
  input mips_pkg::word_t imem_addr,
  input logic            retire_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  int   failures = 0;  // summed into the final count.
  logic xfer;

  assign xfer = imem_valid && imem_ready;  // handshake edge.

  // request and address hold until the memory accepts.
  stall_hold: assert property (@(posedge clk) disable iff (reset)
    imem_valid && !imem_ready |=> imem_valid && $stable(imem_addr))
    else begin
      $error("fetch request or address changed while the memory stalled");
      failures++;
    end

  // retire rises two edges after the transfer edge, three samples later.
  retire_timing: assert property (@(posedge clk) disable iff (reset)
    retire_valid == $past(xfer, 3))
    else begin
      $error("retire did not follow the transfer by exactly two cycles");
      failures++;
    end

  retire_pulse: assert property (@(posedge clk) disable iff (reset)
    retire_valid |=> !retire_valid)
    else begin
      $error("retire_valid stayed high for more than one cycle");
      failures++;
    end

  reset_quiet: assert property (@(posedge clk) reset |=> !imem_valid && !retire_valid)
    else begin
      $error("fetch request or retire strobe active during reset");
      failures++;
    end

endmodule

bind mips_core mips_core_chk u_chk (.clk, .reset, .imem_valid, .imem_ready, .imem_addr,
                                    .retire_valid);

`default_nettype wire

// ==== mips_core_tb.sv ====
`default_nettype none

module mips_core_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import mips_pkg::*;

  localparam int mem_words   = 64;  // program space from the reset vector.
  localparam int max_stall   = 3;   // longest run of ready low.
  localparam int total_instr = 73;  // retires over all six tests.
  localparam int cycle_limit = total_instr * (4 + max_stall) + 6 * 7 + 100;

  logic     clk;
  logic     reset;
  logic     imem_ready;
  instr_t   imem_data;
  logic     imem_valid;
  word_t    imem_addr;
  logic     retire_valid;
  word_t    retire_pc;
  logic     retire_we;
  reg_idx_t retire_rd;
  word_t    retire_data;

  instr_t   mem [mem_words];
  word_t    model_regs [32];  // architectural registers of the model.
  word_t    exp_pc [32];      // predicted retire stream.
  logic     exp_we [32];
  reg_idx_t exp_rd [32];
  word_t    exp_data [32];
  int       n_exp = 0;
  int       n_fetch = 0;
  int       n_retire = 0;
  int       stall_run = 0;
  int       coin;
  int       errors = 0;
  int       tests_run = 0;
  int       tests_failed = 0;
  int       cycles = 0;
  integer   seed;
  logic     stall_en;
  string    test_name;

  mips_core uut (.clk, .reset, .imem_ready, .imem_data, .imem_valid, .imem_addr,
                 .retire_valid, .retire_pc, .retire_we, .retire_rd, .retire_data);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("run stopped at the cycle limit of %0d, the core did not finish", cycle_limit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  function automatic instr_t r_type(input logic [5:0] fn, input reg_idx_t rd, rs, rt);
    return {6'h00, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic instr_t i_type(input logic [5:0] op, input reg_idx_t rt, rs,
                                    input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // unknown opcode 0x3f, low bits folded from the full address.
  function automatic instr_t fill_word(input word_t addr);
    return {6'h3f, addr[25:0] ^ {20'd0, addr[31:26]}};
  endfunction

  function automatic instr_t fetch_word(input word_t addr);
    word_t offset;
    offset = addr - reset_vector;
    if (offset < 4 * mem_words && addr[1:0] == 2'b00) return mem[offset[7:2]];
    return fill_word(addr);
  endfunction

  function automatic int total_errors();
    return errors + uut.u_chk.failures;  // protocol failures count too.
  endfunction

  task automatic report_mismatch(input string what, input word_t expected, input word_t actual);
    $display("Mismatch in test %s, %s: expected %h, actual %h", test_name, what, expected, actual);
    errors++;
  endtask

  task automatic load_program(input int prog, output int count);
    int i;
    for (i = 0; i < mem_words; i++) mem[i] = fill_word(reset_vector + 32'(4 * i));
    case (prog)
      0: begin  // alu results, negative immediates, signed slt.
        mem[0]  = i_type(6'h09, 5'd1, 5'd0, 16'h1234);  // addiu.
        mem[1]  = i_type(6'h09, 5'd2, 5'd0, 16'hfffb);  // -5.
        mem[2]  = r_type(6'h21, 5'd3, 5'd1, 5'd2);      // addu.
        mem[3]  = r_type(6'h23, 5'd4, 5'd2, 5'd1);      // subu.
        mem[4]  = i_type(6'h0f, 5'd5, 5'd0, 16'h8000);  // lui.
        mem[5]  = i_type(6'h0d, 5'd6, 5'd5, 16'hf00f);  // ori, zero extended.
        mem[6]  = r_type(6'h24, 5'd7, 5'd6, 5'd2);      // and.
        mem[7]  = r_type(6'h25, 5'd8, 5'd1, 5'd5);      // or.
        mem[8]  = r_type(6'h2a, 5'd9, 5'd2, 5'd1);      // slt, -5 < 0x1234.
        mem[9]  = r_type(6'h2a, 5'd10, 5'd1, 5'd2);
        mem[10] = r_type(6'h2a, 5'd11, 5'd5, 5'd0);     // most negative word.
        mem[11] = i_type(6'h0d, 5'd12, 5'd0, 16'h8001);
        mem[12] = i_type(6'h09, 5'd13, 5'd12, 16'h8000);
        count = 13;
      end
      1: begin  // register 0.
        mem[0] = i_type(6'h09, 5'd0, 5'd0, 16'h0055);
        mem[1] = i_type(6'h0d, 5'd0, 5'd0, 16'hffff);
        mem[2] = r_type(6'h21, 5'd1, 5'd0, 5'd0);
        mem[3] = i_type(6'h09, 5'd2, 5'd0, 16'h0007);
        mem[4] = r_type(6'h23, 5'd3, 5'd0, 5'd2);
        mem[5] = r_type(6'h25, 5'd0, 5'd2, 5'd3);
        mem[6] = r_type(6'h2a, 5'd4, 5'd0, 5'd2);
        count = 7;
      end
      2: begin  // branches and jump with delay slots.
        mem[0]  = i_type(6'h09, 5'd1, 5'd0, 16'h0001);
        mem[1]  = i_type(6'h09, 5'd2, 5'd0, 16'h0001);
        mem[2]  = i_type(6'h09, 5'd3, 5'd0, 16'h0002);
        mem[3]  = i_type(6'h04, 5'd2, 5'd1, 16'h0003);  // beq taken to word 7.
        mem[4]  = i_type(6'h09, 5'd4, 5'd0, 16'h0011);  // slot.
        mem[5]  = i_type(6'h09, 5'd4, 5'd0, 16'h0022);
        mem[6]  = i_type(6'h09, 5'd4, 5'd0, 16'h0033);
        mem[7]  = i_type(6'h04, 5'd3, 5'd1, 16'h0005);  // beq not taken.
        mem[8]  = i_type(6'h09, 5'd5, 5'd0, 16'h0044);
        mem[9]  = i_type(6'h05, 5'd3, 5'd1, 16'h0002);  // bne taken to word 12.
        mem[10] = i_type(6'h09, 5'd6, 5'd0, 16'h0055);
        mem[11] = i_type(6'h09, 5'd6, 5'd0, 16'h0066);
        mem[12] = i_type(6'h05, 5'd2, 5'd1, 16'hfff0);  // bne not taken.
        mem[13] = i_type(6'h09, 5'd7, 5'd0, 16'h0077);
        mem[14] = {6'h02, 26'h3f0_0014};                // j to word 20.
        mem[15] = i_type(6'h09, 5'd8, 5'd0, 16'h0088);
        mem[18] = i_type(6'h09, 5'd10, 5'd9, 16'h0001);
        mem[19] = i_type(6'h09, 5'd11, 5'd0, 16'h00bb);
        mem[20] = i_type(6'h04, 5'd0, 5'd0, 16'hfffd);  // backward to word 18.
        mem[21] = i_type(6'h09, 5'd9, 5'd0, 16'h0099);
        count = 17;
      end
      default: begin  // unsupported encodings.
        mem[0] = i_type(6'h09, 5'd1, 5'd0, 16'h0010);
        mem[1] = i_type(6'h23, 5'd2, 5'd1, 16'h0004);  // lw.
        mem[2] = r_type(6'h20, 5'd3, 5'd1, 5'd1);      // add, unsupported funct.
        mem[3] = i_type(6'h3f, 5'd5, 5'd1, 16'h1234);
        mem[4] = i_type(6'h09, 5'd2, 5'd1, 16'h0001);
        mem[5] = r_type(6'h21, 5'd4, 5'd2, 5'd1);
        count = 6;
      end
    endcase
  endtask

  task automatic predict(input int count);
    word_t    pc;
    word_t    seq_pc;
    word_t    target;
    word_t    tgt;
    word_t    a;
    word_t    b;
    word_t    simm;
    word_t    result;
    instr_t   ins;
    reg_idx_t rd;
    logic     pending;
    logic     taken;
    logic     we;
    int       k;
    pc = reset_vector;
    pending = 1'b0;
    target = '0;
    for (k = 0; k < count; k++) begin
      ins = fetch_word(pc);
      seq_pc = pc + 32'd4;
      a = model_regs[ins[25:21]];
      b = model_regs[ins[20:16]];
      simm = {{16{ins[15]}}, ins[15:0]};
      tgt = seq_pc + {simm[29:0], 2'b00};  // branch offset counts words.
      rd = ins[20:16];
      result = '0;
      taken = 1'b0;
      we = 1'b1;
      case (ins[31:26])
        6'h00: begin
          rd = ins[15:11];
          case (ins[5:0])
            6'h21:   result = a + b;
            6'h23:   result = a - b;
            6'h24:   result = a & b;
            6'h25:   result = a | b;
            6'h2a:   result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: we = 1'b0;
          endcase
        end
        6'h09:   result = a + simm;
        6'h0d:   result = a | {16'h0000, ins[15:0]};
        6'h0f:   result = {ins[15:0], 16'h0000};
        6'h04:   {we, taken} = {1'b0, a == b};
        6'h05:   {we, taken} = {1'b0, a != b};
        6'h02: begin
          {we, taken} = 2'b01;
          tgt = {seq_pc[31:28], ins[25:0], 2'b00};
        end
        default: we = 1'b0;  // no-op.
      endcase
      we = we && (rd != 5'd0);
      if (we) model_regs[rd] = result;
      exp_pc[k] = pc;
      exp_we[k] = we;
      exp_rd[k] = rd;
      exp_data[k] = result;
      if (pending) pc = target;  // slot done, redirect.
      else pc = seq_pc;
      if (taken) target = tgt;
      pending = taken;
    end
  endtask

  task automatic check_retire();
    if (n_retire >= n_exp) begin
      $display("test %s retired an instruction that was never predicted", test_name);
      errors++;
    end else begin
      assert (retire_pc === exp_pc[n_retire])
        else report_mismatch("retire_pc", exp_pc[n_retire], retire_pc);
      assert (retire_we === exp_we[n_retire])
        else report_mismatch("retire_we", 32'(exp_we[n_retire]), 32'(retire_we));
      if (exp_we[n_retire]) begin
        assert (retire_rd === exp_rd[n_retire])
          else report_mismatch("retire_rd", 32'(exp_rd[n_retire]), 32'(retire_rd));
        assert (retire_data === exp_data[n_retire])
          else report_mismatch("retire_data", exp_data[n_retire], retire_data);
      end
      n_retire++;
    end
  endtask

  // memory model, one random draw per cycle keeps the stall pattern fixed.
  always @(negedge clk) begin
    coin = $random(seed);
    if (!reset && retire_valid) check_retire();
    if (n_fetch >= n_exp) begin
      imem_ready = 1'b0;  // program fully fetched, park the core.
    end else if (stall_en && stall_run < max_stall && (coin & 32'd3) == 0) begin
      imem_ready = 1'b0;
      stall_run++;
    end else begin
      imem_ready = 1'b1;
      stall_run = 0;
    end
    imem_data = fetch_word(imem_addr);
    if (!reset && imem_valid && imem_ready) begin  // transfer at the next edge.
      assert (imem_addr === exp_pc[n_fetch])
        else report_mismatch("imem_addr", exp_pc[n_fetch], imem_addr);
      n_fetch++;
    end
  end

  task automatic run_test(input string name, input int prog, input logic stalls);
    int errors_before;
    int count;
    @(negedge clk);
    reset = 1'b1;
    errors_before = total_errors();
    test_name = name;
    stall_en = stalls;
    load_program(prog, count);
    predict(count);
    n_exp = count;
    n_fetch = 0;
    n_retire = 0;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    wait (n_retire == n_exp);
    @(negedge clk);
    tests_run++;
    if (total_errors() == errors_before) begin
      $display("test %s passed, %0d instructions retired", name, count);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, total_errors() - errors_before);
    end
  endtask

  initial begin
    seed = 32'h2c78_55bf;
    reset = 1'b1;
    imem_ready = 1'b0;
    imem_data = '0;
    stall_en = 1'b0;
    model_regs[0] = '0;
    run_test("alu", 0, 1'b0);
    run_test("zero_reg", 1, 1'b0);
    run_test("branch", 2, 1'b0);
    run_test("unknown_op", 3, 1'b0);
    run_test("alu_stall", 0, 1'b1);
    run_test("branch_stall", 2, 1'b1);
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors());
    if (total_errors() == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
mips_pkg.sv
mips_pc.sv
mips_sequencer.sv
mips_decode.sv
mips_regfile.sv
mips_execute.sv
mips_result.sv
mips_core.sv
mips_core_chk.sv
mips_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mips_core_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TESTBENCH PASSED
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)

run: build
	./$(OBJ_DIR)/$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
